// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int WORD_SIZE  = 16;
    localparam int OPCODE_W   = 4;
    localparam int FUNC_W     = 6;
    localparam int REG_ADDR_W = 2;
    localparam int NUM_REGS   = 4;
    localparam int IMM_W      = 8;
    localparam int TARGET_W   = 12;

    // --------------------------------------------------
    // Opcodes, instr[15:12]
    // --------------------------------------------------
    localparam logic [OPCODE_W-1:0] BNE_OP = 4'd0;
    localparam logic [OPCODE_W-1:0] BEQ_OP = 4'd1;
    localparam logic [OPCODE_W-1:0] BGZ_OP = 4'd2;
    localparam logic [OPCODE_W-1:0] BLZ_OP = 4'd3;
    localparam logic [OPCODE_W-1:0] ADI_OP = 4'd4;
    localparam logic [OPCODE_W-1:0] ORI_OP = 4'd5;
    localparam logic [OPCODE_W-1:0] LHI_OP = 4'd6;
    localparam logic [OPCODE_W-1:0] LWD_OP = 4'd7;
    localparam logic [OPCODE_W-1:0] SWD_OP = 4'd8;
    localparam logic [OPCODE_W-1:0] JMP_OP = 4'd9;
    localparam logic [OPCODE_W-1:0] JAL_OP = 4'd10;
    localparam logic [OPCODE_W-1:0] ALU_OP = 4'd15;
    localparam logic [OPCODE_W-1:0] JPR_OP = 4'd15;    // Shares the R-type opcode.
    localparam logic [OPCODE_W-1:0] JRL_OP = 4'd15;

    // --------------------------------------------------
    // Function codes, instr[5:0]
    // --------------------------------------------------
    localparam logic [FUNC_W-1:0] FUNC_ADD = 6'd0;
    localparam logic [FUNC_W-1:0] FUNC_SUB = 6'd1;
    localparam logic [FUNC_W-1:0] FUNC_AND = 6'd2;
    localparam logic [FUNC_W-1:0] FUNC_ORR = 6'd3;
    localparam logic [FUNC_W-1:0] FUNC_NOT = 6'd4;
    localparam logic [FUNC_W-1:0] FUNC_TCP = 6'd5;
    localparam logic [FUNC_W-1:0] FUNC_SHL = 6'd6;
    localparam logic [FUNC_W-1:0] FUNC_SHR = 6'd7;
    localparam logic [FUNC_W-1:0] FUNC_JPR = 6'd25;
    localparam logic [FUNC_W-1:0] FUNC_JRL = 6'd26;
    localparam logic [FUNC_W-1:0] FUNC_WWD = 6'd28;
    localparam logic [FUNC_W-1:0] FUNC_HLT = 6'd29;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR,
        ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR,
        ALU_LHI, ALU_EQ,  ALU_NE,  ALU_GZ,
        ALU_LZ
    } alu_op_t;

    typedef enum logic [2:0] {
        S_IF, S_ID, S_EX, S_MEM, S_WB, S_HALT
    } cpu_state_t;

    typedef enum logic [1:0] {
        PC_PLUS1, PC_BRANCH, PC_JUMP, PC_REG
    } pc_sel_t;

endpackage

`default_nettype wire

// File: common/ctrl_if.sv
`default_nettype none

interface ctrl_if
    import cpu_pkg::*;
();

    logic       alu_src;
    logic       reg_write;
    logic       mem_read;
    logic       mem_to_reg;
    logic       mem_write;
    logic [1:0] jp;          // 0 none, 1 jump target, 2 register target.
    logic       branch;
    logic       pc_to_reg;
    logic [1:0] rt_write;    // 0 rd, 1 rt, 2 link register.
    logic       out_write;
    logic       halt;
    alu_op_t    alu_op;

    modport dec (
        output alu_src, reg_write, mem_read, mem_to_reg, mem_write, jp,
               branch, pc_to_reg, rt_write, out_write, halt, alu_op
    );

    modport seq (
        input reg_write, mem_read, mem_write, jp, branch, out_write, halt
    );

    modport dp (
        input alu_src, alu_op, jp, branch
    );

endinterface

`default_nettype wire

// File: dv/cpu_patterns.txt
# I: start address and four instruction words. D: data address and word.
# E: expected output_port value, in order. S: store address and data. N: retired count.
I 0000 6112 5534 F41C 42FB # LHI r1, ORI r1, WWD r1, ADI r2 = -5
I 0004 F6C0 FC1C F6C1 FC1C # ADD, SUB into r3
I 0008 F6C2 FC1C F6C3 FC1C # AND, ORR
I 000C F4C4 FC1C F4C5 FC1C # NOT, TCP of r1
I 0010 F4C6 FC1C F8C7 FC1C # SHL r1, SHR r2
I 0014 4040 8105 7305 FC1C # r0 = 0x40, SWD r1 to 0x45, LWD r3 back
I 0018 73FF FC1C 1501 F81C # LWD from 0x3F, BEQ taken
I 001C 0501 F01C 0601 F41C # BNE not taken, BNE taken
I 0020 1601 F81C 2401 F41C # BEQ not taken, BGZ taken
I 0024 2801 F01C 3801 F81C # BGZ not taken, BLZ taken
I 0028 3401 F41C 902D F41C # BLZ not taken, JMP 0x2D
I 002C F41C A030 F41C F41C # JAL 0x30
I 0030 F81C 43F4 FC1A F41C # WWD link, r3 = 0x34, JRL r3
I 0034 F81C 4F04 FC19 F41C # WWD link, r3 = 0x38, JPR r3
I 0038 F01D F01D F01D F01D # HLT
D 003F BEEF
S 0045 1234
E 1234
E 122F
E 1239
E 1230
E FFFF
E EDCB
E EDCC
E 2468
E FFFD
E 1234
E BEEF
E 0040
E FFFB
E 0040
E 1234
E 002E
E 0033
N 002F

// File: dv/tb_cpu_top.sv
`default_nettype none

module tb_cpu_top
    import cpu_pkg::*;
();

    localparam int WAIT_LIMIT = 200;
    localparam int HALT_WATCH = 20;
    localparam int MEM_WORDS  = 65536;

    localparam logic [WORD_SIZE-1:0] RESET_PC = 16'h0000;

    logic                 clk;
    logic                 rst;
    logic [WORD_SIZE-1:0] i_addr;
    logic                 i_read;
    logic [WORD_SIZE-1:0] i_data;
    logic [WORD_SIZE-1:0] d_addr;
    logic                 d_read;
    logic                 d_write;
    logic [WORD_SIZE-1:0] d_wdata;
    logic [WORD_SIZE-1:0] d_rdata;
    logic [WORD_SIZE-1:0] output_port;
    logic                 output_valid;
    logic [WORD_SIZE-1:0] num_inst;
    logic                 halted;

    logic [WORD_SIZE-1:0] imem [MEM_WORDS];
    logic [WORD_SIZE-1:0] dmem [MEM_WORDS];
    logic [WORD_SIZE-1:0] exp_out [$];
    logic [WORD_SIZE-1:0] exp_st_addr [$];
    logic [WORD_SIZE-1:0] exp_st_data [$];
    logic [WORD_SIZE-1:0] exp_count;
    int                   fetch_count;

    logic                 i_req;
    logic                 d_rd_req;
    logic                 d_wr_req;
    logic [WORD_SIZE-1:0] i_req_addr;
    logic [WORD_SIZE-1:0] d_req_addr;
    logic [WORD_SIZE-1:0] d_req_wdata;

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .i_addr       (i_addr),
        .i_read       (i_read),
        .i_data       (i_data),
        .d_addr       (d_addr),
        .d_read       (d_read),
        .d_write      (d_write),
        .d_wdata      (d_wdata),
        .d_rdata      (d_rdata),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .halted       (halted)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [WORD_SIZE-1:0] expected,
                           input logic [WORD_SIZE-1:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("FAIL %s: expected 0x%h, actual 0x%h", name, expected, actual));
        end
    endtask

    task automatic load_patterns();
        integer               fd;
        integer               code;
        int                   k;
        logic [7:0]           tag;
        logic [WORD_SIZE-1:0] addr;
        logic [WORD_SIZE-1:0] value;
        logic [8*128-1:0]     rest;
        fd = $fopen("dv/cpu_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the pattern file dv/cpu_patterns.txt.");
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "#": code = $fgets(rest, fd);    // Comment up to the end of the line.
                "I": begin
                    code = $fscanf(fd, "%h", addr);
                    for (k = 0; k < 4; k++) begin
                        code = $fscanf(fd, "%h", value);
                        imem[addr + k] = value;
                    end
                end
                "D": begin
                    code = $fscanf(fd, "%h %h", addr, value);
                    dmem[addr] = value;
                end
                "E": begin
                    code = $fscanf(fd, "%h", value);
                    exp_out.push_back(value);
                end
                "S": begin
                    code = $fscanf(fd, "%h %h", addr, value);
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(value);
                end
                "N": code = $fscanf(fd, "%h", exp_count);
                default: abort_run("The pattern file holds a line with an unknown tag.");
            endcase
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------
    // Memory models, one cycle of read latency
    // --------------------------------------------------
    always @(negedge clk) begin
        i_req       = i_read;
        i_req_addr  = i_addr;
        d_rd_req    = d_read;
        d_wr_req    = d_write;
        d_req_addr  = d_addr;
        d_req_wdata = d_wdata;
        if (i_read && !rst) begin
            fetch_count++;    // Every executed instruction starts with one fetch.
        end
        if (d_write) begin
            if (exp_st_addr.size() == 0) begin
                abort_run("A store appeared on the data port that no pattern expects.");
            end
            compare("store address", exp_st_addr.pop_front(), d_addr);
            compare("store data", exp_st_data.pop_front(), d_wdata);
        end
    end

    always @(posedge clk) begin
        #1;
        if (i_req) begin
            i_data = imem[i_req_addr];
        end
        if (d_rd_req) begin
            d_rdata = dmem[d_req_addr];
        end
        if (d_wr_req) begin
            dmem[d_req_addr] = d_req_wdata;
        end
    end

    initial begin
        int n;
        int cycles;
        int a;
        clk      = 1'b0;
        rst      = 1'b1;
        i_data   = '0;
        d_rdata  = '0;
        i_req    = 1'b0;
        d_rd_req = 1'b0;
        d_wr_req = 1'b0;
        exp_count = '0;
        fetch_count = 0;
        for (a = 0; a < MEM_WORDS; a++) begin
            imem[a] = WORD_SIZE'(a) ^ 16'h5a3c;
            dmem[a] = ~WORD_SIZE'(a);
        end
        load_patterns();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        compare("pc after reset", RESET_PC, i_addr);
        compare("num_inst after reset", '0, num_inst);
        compare("halted after reset", '0, {15'b0, halted});
        compare("d_read after reset", '0, {15'b0, d_read});
        compare("d_write after reset", '0, {15'b0, d_write});
        compare("output_valid after reset", '0, {15'b0, output_valid});

        // --------------------------------------------------
        // Output sequence, then halt
        // --------------------------------------------------
        for (n = 0; n < exp_out.size(); n++) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (halted) begin
                    abort_run($sformatf("The CPU halted before output %0d appeared.", n));
                end
            end while (!output_valid && cycles < WAIT_LIMIT);
            if (!output_valid) begin
                abort_run($sformatf("Timed out waiting for output %0d.", n));
            end
            compare($sformatf("output %0d", n), exp_out[n], output_port);
        end
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (output_valid) begin
                abort_run("An output appeared beyond the expected list.");
            end
        end while (!halted && cycles < WAIT_LIMIT);
        if (!halted) begin
            abort_run("Timed out waiting for the CPU to halt.");
        end
        for (n = 0; n < HALT_WATCH; n++) begin
            @(negedge clk);
            compare("halted held", 16'd1, {15'b0, halted});
            compare("output_valid after halt", '0, {15'b0, output_valid});
        end
        compare("retired count", exp_count, num_inst);
        compare("fetch count", exp_count, WORD_SIZE'(fetch_count));
        compare("stores left", '0, WORD_SIZE'(exp_st_addr.size()));
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`default_nettype none

module alu
    import cpu_pkg::*;
(
    ctrl_if.dp                   ctrl,
    input  wire [WORD_SIZE-1:0]  a,
    input  wire [WORD_SIZE-1:0]  b_reg,
    input  wire [IMM_W-1:0]      imm,
    output logic [WORD_SIZE-1:0] result,
    output logic                 branch_taken
);

    logic [WORD_SIZE-1:0] imm_ext;
    logic [WORD_SIZE-1:0] b;
    logic                 cond;

    // ORI zero-extends its immediate. The other immediate forms are signed.
    assign imm_ext = (ctrl.alu_op == ALU_ORR) ? {{(WORD_SIZE-IMM_W){1'b0}}, imm}
                                              : {{(WORD_SIZE-IMM_W){imm[IMM_W-1]}}, imm};

    assign b = ctrl.alu_src ? imm_ext : b_reg;

    always_comb begin
        result = '0;
        cond   = 1'b0;
        case (ctrl.alu_op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_ORR: result = a | b;
            ALU_NOT: result = ~a;
            ALU_TCP: result = ~a + 1'b1;
            ALU_SHL: result = {a[WORD_SIZE-2:0], 1'b0};
            ALU_SHR: result = {a[WORD_SIZE-1], a[WORD_SIZE-1:1]};    // Keeps the sign.
            ALU_LHI: result = {imm, {(WORD_SIZE-IMM_W){1'b0}}};
            ALU_EQ:  cond   = (a == b);
            ALU_NE:  cond   = (a != b);
            ALU_GZ:  cond   = ($signed(a) > 0);
            ALU_LZ:  cond   = a[WORD_SIZE-1];
            default: result = '0;
        endcase
    end

    assign branch_taken = ctrl.branch & cond;

endmodule

`default_nettype wire

// File: rtl/control_unit.sv
`default_nettype none

module control_unit
    import cpu_pkg::*;
(
    input  wire [WORD_SIZE-1:0] instr,
    ctrl_if.dec                 ctrl
);

    logic [OPCODE_W-1:0] opcode;
    logic [FUNC_W-1:0]   func_code;

    assign opcode    = instr[15:12];
    assign func_code = instr[5:0];

    function automatic alu_op_t func_to_alu(input logic [FUNC_W-1:0] func);
        alu_op_t op;
        case (func)
            FUNC_ADD: op = ALU_ADD;
            FUNC_SUB: op = ALU_SUB;
            FUNC_AND: op = ALU_AND;
            FUNC_ORR: op = ALU_ORR;
            FUNC_NOT: op = ALU_NOT;
            FUNC_TCP: op = ALU_TCP;
            FUNC_SHL: op = ALU_SHL;
            FUNC_SHR: op = ALU_SHR;
            default:  op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl.alu_src    = 1'b0;    // Every control starts inactive.
        ctrl.reg_write  = 1'b0;
        ctrl.mem_read   = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.jp         = 2'd0;
        ctrl.branch     = 1'b0;
        ctrl.pc_to_reg  = 1'b0;
        ctrl.rt_write   = 2'd0;
        ctrl.out_write  = 1'b0;
        ctrl.halt       = 1'b0;
        ctrl.alu_op     = ALU_ADD;
        case (opcode)
            ALU_OP, JPR_OP, JRL_OP: begin
                case (func_code)
                    FUNC_JPR: begin
                        ctrl.jp = 2'd2;
                    end
                    FUNC_JRL: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.jp        = 2'd2;
                        ctrl.pc_to_reg = 1'b1;
                        ctrl.rt_write  = 2'd2;
                    end
                    FUNC_WWD: ctrl.out_write = 1'b1;
                    FUNC_HLT: ctrl.halt      = 1'b1;
                    default: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = func_to_alu(func_code);
                    end
                endcase
            end
            ADI_OP, ORI_OP, LHI_OP: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.rt_write  = 2'd1;
                if (opcode == ORI_OP) begin
                    ctrl.alu_op = ALU_ORR;
                end else if (opcode == LHI_OP) begin
                    ctrl.alu_op = ALU_LHI;
                end
            end
            LWD_OP: begin
                ctrl.alu_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.rt_write   = 2'd1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            SWD_OP: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            BNE_OP, BEQ_OP: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = (opcode == BNE_OP) ? ALU_NE : ALU_EQ;
            end
            BGZ_OP, BLZ_OP: begin
                ctrl.alu_src = 1'b1;
                ctrl.branch  = 1'b1;
                ctrl.alu_op  = (opcode == BGZ_OP) ? ALU_GZ : ALU_LZ;
            end
            JMP_OP: ctrl.jp = 2'd1;
            JAL_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.jp        = 2'd1;
                ctrl.pc_to_reg = 1'b1;
                ctrl.rt_write  = 2'd2;
            end
            default: ;    // Unknown opcodes behave as a no-op.
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/cpu_fsm.sv
`default_nettype none

module cpu_fsm
    import cpu_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    ctrl_if.seq                  ctrl,
    input  wire [WORD_SIZE-1:0]  i_data,
    output logic [WORD_SIZE-1:0] ir,
    output logic                 i_read,
    output logic                 ir_load,
    output logic                 pc_load,
    output logic                 rf_we,
    output logic                 d_read,
    output logic                 d_write,
    output logic                 output_valid,
    output logic                 retire,
    output logic                 halted
);

    cpu_state_t state;
    cpu_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IF;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir <= i_data;    // Memory answers the S_IF strobe in this cycle.
        end
    end

    // --------------------------------------------------
    // Next state and one-cycle strobes
    // --------------------------------------------------
    always_comb begin
        state_next   = state;
        i_read       = 1'b0;
        ir_load      = 1'b0;
        pc_load      = 1'b0;
        rf_we        = 1'b0;
        d_read       = 1'b0;
        d_write      = 1'b0;
        output_valid = 1'b0;
        retire       = 1'b0;
        case (state)
            S_IF: begin
                i_read     = 1'b1;
                state_next = S_ID;
            end
            S_ID: begin
                ir_load    = 1'b1;
                state_next = S_EX;
            end
            S_EX: begin
                if (ctrl.halt) begin
                    retire     = 1'b1;
                    state_next = S_HALT;
                end else if (ctrl.out_write || ctrl.branch || ctrl.jp != 2'd0) begin
                    output_valid = ctrl.out_write;
                    rf_we        = ctrl.reg_write;    // Link write of JAL and JRL.
                    pc_load      = 1'b1;
                    retire       = 1'b1;
                    state_next   = S_IF;
                end else if (ctrl.mem_read || ctrl.mem_write) begin
                    state_next = S_MEM;
                end else begin
                    state_next = S_WB;
                end
            end
            S_MEM: begin
                d_read  = ctrl.mem_read;
                d_write = ctrl.mem_write;
                if (ctrl.mem_write) begin
                    pc_load    = 1'b1;
                    retire     = 1'b1;
                    state_next = S_IF;
                end else begin
                    state_next = S_WB;    // Load data arrives in the next cycle.
                end
            end
            S_WB: begin
                rf_we      = ctrl.reg_write;
                pc_load    = 1'b1;
                retire     = 1'b1;
                state_next = S_IF;
            end
            S_HALT: state_next = S_HALT;
            default: state_next = S_IF;
        endcase
    end

    assign halted = (state == S_HALT);

    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst) !(d_read && d_write));

    a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted);

endmodule

`default_nettype wire

// File: rtl/cpu_top.sv
`default_nettype none

module cpu_top
    import cpu_pkg::*;
#(
    parameter logic [WORD_SIZE-1:0] RESET_PC = '0
)(
    input  wire                  clk,
    input  wire                  rst,
    output logic [WORD_SIZE-1:0] i_addr,
    output logic                 i_read,
    input  wire [WORD_SIZE-1:0]  i_data,
    output logic [WORD_SIZE-1:0] d_addr,
    output logic                 d_read,
    output logic                 d_write,
    output logic [WORD_SIZE-1:0] d_wdata,
    input  wire [WORD_SIZE-1:0]  d_rdata,
    output logic [WORD_SIZE-1:0] output_port,
    output logic                 output_valid,
    output logic [WORD_SIZE-1:0] num_inst,
    output logic                 halted
);

    logic [WORD_SIZE-1:0]  ir;
    logic [WORD_SIZE-1:0]  pc;
    logic                  pc_load;
    logic                  rf_we;
    logic                  retire;
    logic                  branch_taken;
    logic [WORD_SIZE-1:0]  rd1;
    logic [WORD_SIZE-1:0]  rd2;
    logic [WORD_SIZE-1:0]  alu_result;
    logic [REG_ADDR_W-1:0] wa;
    logic [WORD_SIZE-1:0]  wd;

    ctrl_if ctrl ();

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    control_unit u_control_unit (
        .instr (ir),
        .ctrl  (ctrl.dec)
    );

    cpu_fsm u_cpu_fsm (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl.seq),
        .i_data       (i_data),
        .ir           (ir),
        .i_read       (i_read),
        .ir_load      (),    // Used inside the FSM only.
        .pc_load      (pc_load),
        .rf_we        (rf_we),
        .d_read       (d_read),
        .d_write      (d_write),
        .output_valid (output_valid),
        .retire       (retire),
        .halted       (halted)
    );

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc_unit (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl.dp),
        .pc_load      (pc_load),
        .branch_taken (branch_taken),
        .imm          (ir[7:0]),
        .jump_target  (ir[11:0]),
        .reg_target   (rd1),
        .retire       (retire),
        .pc           (pc),
        .num_inst     (num_inst)
    );

    alu u_alu (
        .ctrl         (ctrl.dp),
        .a            (rd1),
        .b_reg        (rd2),
        .imm          (ir[7:0]),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    reg_file u_reg_file (
        .clk (clk),
        .rst (rst),
        .rs  (ir[11:10]),
        .rt  (ir[9:8]),
        .we  (rf_we),
        .wa  (wa),
        .wd  (wd),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    assign wa = (ctrl.rt_write == 2'd2) ? 2'd2 :    // Link register.
                (ctrl.rt_write == 2'd1) ? ir[9:8] : ir[7:6];

    assign wd = ctrl.pc_to_reg  ? pc + 1'b1 :
                ctrl.mem_to_reg ? d_rdata   : alu_result;

    assign i_addr      = pc;
    assign d_addr      = alu_result;
    assign d_wdata     = rd2;
    assign output_port = rd1;

endmodule

`default_nettype wire

// File: rtl/pc_unit.sv
`default_nettype none

module pc_unit
    import cpu_pkg::*;
#(
    parameter logic [WORD_SIZE-1:0] RESET_PC = '0
)(
    input  wire                  clk,
    input  wire                  rst,
    ctrl_if.dp                   ctrl,
    input  wire                  pc_load,
    input  wire                  branch_taken,
    input  wire [IMM_W-1:0]      imm,
    input  wire [TARGET_W-1:0]   jump_target,
    input  wire [WORD_SIZE-1:0]  reg_target,
    input  wire                  retire,
    output logic [WORD_SIZE-1:0] pc,
    output logic [WORD_SIZE-1:0] num_inst
);

    pc_sel_t              pc_sel;
    logic [WORD_SIZE-1:0] pc_plus1;
    logic [WORD_SIZE-1:0] pc_next;

    assign pc_plus1 = pc + 1'b1;

    assign pc_sel = (ctrl.jp == 2'd1) ? PC_JUMP :
                    (ctrl.jp == 2'd2) ? PC_REG :
                    branch_taken      ? PC_BRANCH : PC_PLUS1;

    always_comb begin
        case (pc_sel)
            PC_BRANCH: pc_next = pc_plus1 + {{(WORD_SIZE-IMM_W){imm[IMM_W-1]}}, imm};
            PC_JUMP:   pc_next = {pc[WORD_SIZE-1:TARGET_W], jump_target};    // Same page.
            PC_REG:    pc_next = reg_target;
            default:   pc_next = pc_plus1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= RESET_PC;
            num_inst <= '0;
        end else begin
            if (pc_load) begin
                pc <= pc_next;
            end
            if (retire) begin
                num_inst <= num_inst + 1'b1;
            end
        end
    end

    a_pc_load_ok: assert property (@(posedge clk) disable iff (rst)
        pc_load |-> (retire || ctrl.branch));

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire [REG_ADDR_W-1:0] rs,
    input  wire [REG_ADDR_W-1:0] rt,
    input  wire                  we,
    input  wire [REG_ADDR_W-1:0] wa,
    input  wire [WORD_SIZE-1:0]  wd,
    output logic [WORD_SIZE-1:0] rd1,
    output logic [WORD_SIZE-1:0] rd2
);

    logic [WORD_SIZE-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // Reads see the old value during the write cycle.
    assign rd1 = regs[rs];
    assign rd2 = regs[rt];

endmodule

`default_nettype wire

// File: src.f
common/cpu_pkg.sv
common/ctrl_if.sv
rtl/control_unit.sv
rtl/cpu_fsm.sv
rtl/pc_unit.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/cpu_top.sv
dv/tb_cpu_top.sv
